/* hdl/apb_fir_filter.sv */
`timescale 1ns/1ps

module apb_fir_filter (
  input  logic                      tb_clk,
  input  logic                      rst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  fir_regmap_pkg::apb_addr_t paddr,
  input  fir_regmap_pkg::apb_data_t pwdata,
  output fir_regmap_pkg::apb_data_t prdata,
  output logic                      pready,
  output logic                      pslverr
);

  // ****************************
  // Internal links
  // ****************************

  // Bus block to engine
  fir_host_if host_if ();

  // Sequencer to arithmetic
  fir_mac_if mac_if ();

  // ****************************
  // Blocks
  // ****************************

  // APB slave and coefficient staging
  apb_fir_regs i_apb_fir_regs (
    .tb_clk  (tb_clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .host    (host_if.regs)
  );

  // Tap stepping FSM
  fir_mac_ctrl i_fir_mac_ctrl (
    .tb_clk (tb_clk),
    .rst    (rst),
    .host   (host_if.ctrl),
    .mac    (mac_if.ctrl)
  );

  // Window, taps and accumulator
  fir_datapath i_fir_datapath (
    .tb_clk (tb_clk),
    .rst    (rst),
    .host   (host_if.dp),
    .mac    (mac_if.dp)
  );

endmodule

/* hdl/apb_fir_regs.sv */
`timescale 1ns/1ps

module apb_fir_regs (
  input  logic                      tb_clk,
  input  logic                      rst,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  fir_regmap_pkg::apb_addr_t paddr,
  input  fir_regmap_pkg::apb_data_t pwdata,
  output fir_regmap_pkg::apb_data_t prdata,
  output logic                      pready,
  output logic                      pslverr,
  fir_host_if.regs                  host
);
  import fir_arith_pkg::*;
  import fir_regmap_pkg::*;

  typedef enum logic {CP_IDLE, CP_RUN} copy_state_t;

  localparam tap_idx_t LAST_TAP = tap_idx_t'(NUM_TAPS - 1);

  coef_t       staged [NUM_TAPS];
  sample_t     last_sample;
  copy_state_t copy_state;
  tap_idx_t    copy_tap;

  logic        access;
  logic        access_err;
  logic        wr_ok;
  logic        set_wr;
  logic        is_coef;
  tap_idx_t    coef_sel;
  logic        copy_active;
  logic        busy_all;
  apb_data_t   status_word;

  // ****************************
  // Address decode
  // ****************************

  assign access = psel & penable;

  // Halfword slot index relative to the first coefficient
  assign coef_sel = tap_idx_t'(paddr[3:1] - ADDR_COEF_BASE[3:1]);
  assign is_coef  = (paddr >= ADDR_COEF_BASE) && (paddr < ADDR_COEF_SET) && !paddr[0];

  // 4 bit byte space so every even address maps to a register
  always_comb
  begin
    access_err = paddr[0];
    // Status and result are read only
    if (pwrite && (paddr == ADDR_STATUS || paddr == ADDR_RESULT))
      access_err = 1'b1;
    // Only a 1 may be written to coef_set
    if (pwrite && paddr == ADDR_COEF_SET && pwdata != apb_data_t'(1))
      access_err = 1'b1;
  end

  // Hold a sample write off until the engine and copy are both done
  assign copy_active = (copy_state == CP_RUN);
  assign busy_all    = host.busy | copy_active;
  assign pready      = ~(access & pwrite & (paddr == ADDR_SAMPLE) & busy_all);
  assign pslverr     = access & access_err;

  // Errored writes are dropped
  assign wr_ok  = access & pready & pwrite & ~access_err;
  assign set_wr = wr_ok & (paddr == ADDR_COEF_SET);

  // ****************************
  // Write side
  // ****************************

  always_ff @(posedge tb_clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_TAPS; i++)
        staged[i] <= '0;
      last_sample <= '0;
    end
    else
    begin
      if (wr_ok && is_coef)
        staged[coef_sel] <= pwdata;
      if (host.sample_wr)
        last_sample <= pwdata;
    end
  end

  // Sample strobe lands on the completing edge
  assign host.sample_wr = wr_ok & (paddr == ADDR_SAMPLE);
  assign host.sample    = pwdata;

  // ****************************
  // Coefficient copy
  // ****************************

  // One tap per cycle, restarts from tap 0 on a fresh commit
  always_ff @(posedge tb_clk)
  begin
    if (rst)
    begin
      copy_state <= CP_IDLE;
      copy_tap   <= '0;
    end
    else if (set_wr)
    begin
      copy_state <= CP_RUN;
      copy_tap   <= '0;
    end
    else if (copy_active)
    begin
      copy_tap <= copy_tap + 1'b1;
      if (copy_tap == LAST_TAP)
        copy_state <= CP_IDLE;
    end
  end

  assign host.coef_wr   = copy_active;
  assign host.coef_idx  = copy_tap;
  assign host.coef_data = staged[copy_tap];

  // ****************************
  // Read side
  // ****************************

  always_comb
  begin
    status_word = '0;
    status_word[STATUS_BUSY_BIT] = busy_all;
    status_word[STATUS_ERR_BIT]  = host.err;
  end

  always_comb
  begin
    prdata = '0;
    case (paddr)
      ADDR_STATUS:   prdata = status_word;
      ADDR_RESULT:   prdata = host.result;
      ADDR_SAMPLE:   prdata = last_sample;
      // coef_set stays at 1 while the copy runs
      ADDR_COEF_SET: prdata[0] = copy_active;
      default:
      begin
        if (is_coef)
          prdata = staged[coef_sel];
      end
    endcase
  end

endmodule

/* hdl/fir_arith_pkg.sv */
package fir_arith_pkg;

  // ****************************
  // Filter shape
  // ****************************

  // Register map has room for exactly four taps
  localparam int NUM_TAPS = 4;

  // Unsigned Q1.15 coefficients so 16'h8000 is unity gain
  localparam int COEF_FRAC_BITS = 15;

  // ****************************
  // Arithmetic widths
  // ****************************

  // Raw sample as written by the host
  typedef logic [15:0] sample_t;

  // Fixed point tap weight
  typedef logic [15:0] coef_t;

  typedef logic [1:0] tap_idx_t;

  // Sample times weight after the fraction shift
  typedef logic [16:0] prod_t;

  // Four 17 bit terms plus sign
  typedef logic signed [19:0] acc_t;

  // Low half of the final sum
  typedef logic [15:0] result_t;

endpackage

/* hdl/fir_datapath.sv */
`timescale 1ns/1ps

module fir_datapath (
  input  logic    tb_clk,
  input  logic    rst,
  fir_host_if.dp  host,
  fir_mac_if.dp   mac
);
  import fir_arith_pkg::*;

  sample_t     window    [NUM_TAPS];
  coef_t       live_coef [NUM_TAPS];
  acc_t        acc;
  logic [31:0] full_prod;
  prod_t       prod;
  acc_t        term;

  // ****************************
  // Sample window and live taps
  // ****************************

  // Slot 0 holds the newest sample
  always_ff @(posedge tb_clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_TAPS; i++)
      begin
        window[i]    <= '0;
        live_coef[i] <= '0;
      end
    end
    else
    begin
      if (host.sample_wr)
      begin
        window[0] <= host.sample;
        for (int i = 1; i < NUM_TAPS; i++)
          window[i] <= window[i-1];
      end
      if (host.coef_wr)
        live_coef[host.coef_idx] <= host.coef_data;
    end
  end

  // ****************************
  // Multiply and accumulate
  // ****************************

  // Truncating shift drops the fraction bits
  assign full_prod = window[mac.tap] * live_coef[mac.tap];
  assign prod      = prod_t'(full_prod >> COEF_FRAC_BITS);
  assign term      = acc_t'({3'b000, prod});

  // Even taps subtract, odd taps add
  always_ff @(posedge tb_clk)
  begin
    if (mac.clear_acc)
      acc <= '0;
    else if (mac.mac_en)
      acc <= mac.tap[0] ? acc + term : acc - term;
  end

  // ****************************
  // Result and overflow
  // ****************************

  // Sum fits only when the top four bits are clear
  always_ff @(posedge tb_clk)
  begin
    if (rst)
    begin
      host.result <= '0;
      host.err    <= 1'b0;
    end
    else if (mac.commit)
    begin
      host.result <= acc[15:0];
      host.err    <= (acc[19:16] != 4'd0);
    end
  end

endmodule

/* hdl/fir_host_if.sv */
`timescale 1ns/1ps

interface fir_host_if;
  import fir_arith_pkg::*;

  // New sample, one cycle strobe
  logic sample_wr;
  sample_t sample;

  // Live coefficient load from the copy sequencer
  logic coef_wr;
  tap_idx_t coef_idx;
  coef_t coef_data;

  // Engine state back to the register block
  logic busy;
  result_t result;
  logic err;

  // Bus side
  modport regs (output sample_wr, sample, coef_wr, coef_idx, coef_data,
                input busy, result, err);

  // Sequencing side only needs the strobe
  modport ctrl (input sample_wr, output busy);

  // Arithmetic side
  modport dp (input sample_wr, sample, coef_wr, coef_idx, coef_data,
              output result, err);

endinterface

/* hdl/fir_mac_ctrl.sv */
`timescale 1ns/1ps

module fir_mac_ctrl (
  input  logic    tb_clk,
  input  logic    rst,
  fir_host_if.ctrl host,
  fir_mac_if.ctrl  mac
);
  import fir_arith_pkg::*;

  typedef enum logic [1:0] {ST_IDLE, ST_ACCUM, ST_COMMIT} state_t;

  localparam tap_idx_t LAST_TAP = tap_idx_t'(NUM_TAPS - 1);

  state_t   state;
  tap_idx_t tap_cnt;

  // ****************************
  // Sequencer
  // ****************************

  // Idle until a sample lands, then one tap per cycle, then commit
  always_ff @(posedge tb_clk)
  begin
    if (rst)
    begin
      state   <= ST_IDLE;
      tap_cnt <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          tap_cnt <= '0;
          if (host.sample_wr)
            state <= ST_ACCUM;
        end
        ST_ACCUM:
        begin
          tap_cnt <= tap_cnt + 1'b1;
          // Last tap accumulates on this edge
          if (tap_cnt == LAST_TAP)
            state <= ST_COMMIT;
        end
        ST_COMMIT:
          state <= ST_IDLE;
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // ****************************
  // Datapath controls
  // ****************************

  // Clear happens on the same edge the window shifts
  assign mac.clear_acc = (state == ST_IDLE) & host.sample_wr;
  assign mac.mac_en    = (state == ST_ACCUM);
  assign mac.tap       = tap_cnt;
  assign mac.commit    = (state == ST_COMMIT);

  // High from the sample edge to the commit edge
  assign host.busy = (state != ST_IDLE);

endmodule

/* hdl/fir_mac_if.sv */
`timescale 1ns/1ps

interface fir_mac_if;
  import fir_arith_pkg::*;

  // Zero the accumulator before the first tap
  logic clear_acc;

  // Add or subtract one tap term this cycle
  logic mac_en;
  tap_idx_t tap;

  // Latch result and overflow flag
  logic commit;

  modport ctrl (output clear_acc, mac_en, tap, commit);

  modport dp (input clear_acc, mac_en, tap, commit);

endinterface

/* hdl/fir_regmap_pkg.sv */
package fir_regmap_pkg;

  // ****************************
  // Bus widths
  // ****************************

  // Byte address, every register is one halfword
  typedef logic [3:0] apb_addr_t;

  typedef logic [15:0] apb_data_t;

  // ****************************
  // Register map
  // ****************************

  // Read only engine status
  localparam apb_addr_t ADDR_STATUS = 4'd0;

  // Read only filter output
  localparam apb_addr_t ADDR_RESULT = 4'd2;

  // Write pushes a new sample into the window
  localparam apb_addr_t ADDR_SAMPLE = 4'd4;

  // Staged coefficient i sits at base plus 2i
  localparam apb_addr_t ADDR_COEF_BASE = 4'd6;

  // Write 1 to copy staged weights into the live taps
  localparam apb_addr_t ADDR_COEF_SET = 4'd14;

  // ****************************
  // Status word layout
  // ****************************

  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_ERR_BIT = 1;

endpackage

/* src.f */
hdl/fir_arith_pkg.sv
hdl/fir_regmap_pkg.sv
hdl/fir_host_if.sv
hdl/fir_mac_if.sv
hdl/apb_fir_regs.sv
hdl/fir_mac_ctrl.sv
hdl/fir_datapath.sv
hdl/apb_fir_filter.sv
tb/tb_clk_gen.sv
tb/tb_apb_fir_filter.sv

/* tb/tb_apb_fir_filter.sv */
`timescale 1ns/1ps

module tb_apb_fir_filter;
  import fir_arith_pkg::*;
  import fir_regmap_pkg::*;

  localparam int WAIT_LIMIT = 100;

  logic        tb_clk;
  logic        rst;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pready;
  logic        pslverr;

  logic [31:0] lfsr_state;
  int          last_stalls;
  // Reference model state, slot 0 newest
  sample_t     model_window [NUM_TAPS];
  coef_t       model_staged [NUM_TAPS];
  coef_t       model_live   [NUM_TAPS];

  tb_clk_gen i_tb_clk_gen (
    .tb_clk (tb_clk),
    .rst    (rst)
  );

  apb_fir_filter i_apb_fir_filter (
    .tb_clk  (tb_clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

  // ****************************
  // Failure reporting
  // ****************************

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual)
    else
      abort_run($sformatf("ERROR %s: expected %0h, actual %0h", name, expected, actual));
  endtask

  // ****************************
  // APB master
  // ****************************

  // Setup, then access held until pready, outputs sampled mid cycle
  task automatic bus_transfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                              output apb_data_t rdata, output logic err, output int stalls);
    stalls = 0;
    @(posedge tb_clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge tb_clk);
    #1;
    penable = 1'b1;
    #1;
    while (!pready)
    begin
      stalls++;
      if (stalls > WAIT_LIMIT)
        abort_run($sformatf("pready stayed low too long at address %0h", addr));
      @(posedge tb_clk);
      #2;
    end
    rdata = prdata;
    err   = pslverr;
    // Completing edge
    @(posedge tb_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic write_reg(input apb_addr_t addr, input apb_data_t data);
    apb_data_t discard;
    logic      err;
    bus_transfer(1'b1, addr, data, discard, err, last_stalls);
    check_value($sformatf("pslverr on write to %0h", addr), 0, err);
  endtask

  task automatic read_reg(input apb_addr_t addr, output apb_data_t data);
    logic err;
    int   stalls;
    bus_transfer(1'b0, addr, '0, data, err, stalls);
    check_value($sformatf("pslverr on read of %0h", addr), 0, err);
  endtask

  task automatic expect_reg(input string name, input apb_addr_t addr, input apb_data_t expected);
    apb_data_t data;
    read_reg(addr, data);
    check_value(name, expected, data);
  endtask

  // Bus must flag the access as an error
  task automatic expect_rejected(input string name, input logic wr, input apb_addr_t addr,
                                 input apb_data_t data);
    apb_data_t discard;
    logic      err;
    int        stalls;
    bus_transfer(wr, addr, data, discard, err, stalls);
    check_value(name, 1, err);
  endtask

  // ****************************
  // Stimulus helpers
  // ****************************

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
  endfunction

  // One step per bit
  function automatic sample_t random_sample();
    sample_t value;
    int      i;
    value = '0;
    for (i = 0; i < 16; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[14:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic apb_addr_t coef_addr(input int idx);
    return apb_addr_t'(ADDR_COEF_BASE + 2 * idx);
  endfunction

  task automatic set_coef(input int idx, input coef_t value);
    write_reg(coef_addr(idx), value);
    model_staged[idx] = value;
  endtask

  // Copy takes four cycles, poll until coef_set drops
  task automatic commit_coefs();
    apb_data_t data;
    int        polls;
    write_reg(ADDR_COEF_SET, 16'h0001);
    polls = 0;
    read_reg(ADDR_COEF_SET, data);
    while (data != 16'h0000)
    begin
      polls++;
      if (polls > WAIT_LIMIT)
        abort_run("coef_set never returned to 0 after a commit");
      read_reg(ADDR_COEF_SET, data);
    end
    read_reg(ADDR_STATUS, data);
    check_value("busy after commit", 0, data[STATUS_BUSY_BIT]);
    model_live = model_staged;
  endtask

  task automatic send_sample(input sample_t value);
    int i;
    write_reg(ADDR_SAMPLE, value);
    for (i = NUM_TAPS - 1; i > 0; i--)
      model_window[i] = model_window[i-1];
    model_window[0] = value;
  endtask

  task automatic wait_idle();
    apb_data_t status;
    int        polls;
    polls = 0;
    read_reg(ADDR_STATUS, status);
    while (status[STATUS_BUSY_BIT])
    begin
      polls++;
      if (polls > WAIT_LIMIT)
        abort_run("Status busy never cleared");
      read_reg(ADDR_STATUS, status);
    end
  endtask

  // ****************************
  // Reference model
  // ****************************

  // Truncated Q15 products, even taps negative, odd taps positive
  function automatic longint model_sum();
    longint sum;
    longint term;
    int     t;
    sum = 0;
    for (t = 0; t < NUM_TAPS; t++)
    begin
      term = (longint'(model_window[t]) * longint'(model_live[t])) >> COEF_FRAC_BITS;
      if (t % 2 == 0)
        sum = sum - term;
      else
        sum = sum + term;
    end
    return sum;
  endfunction

  task automatic check_output(input string name);
    longint    sum;
    logic      exp_err;
    apb_data_t status;
    wait_idle();
    sum = model_sum();
    // Out of 16 bit unsigned range either way
    exp_err = (sum < 0) || (sum > 65535);
    expect_reg({name, " result"}, ADDR_RESULT, sum[15:0]);
    read_reg(ADDR_STATUS, status);
    check_value({name, " err"}, exp_err, status[STATUS_ERR_BIT]);
  endtask

  // ****************************
  // Test sequence
  // ****************************

  initial
  begin
    apb_data_t status;
    int        cycles;
    int        i;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    lfsr_state = 32'h3013a82b;
    for (i = 0; i < NUM_TAPS; i++)
    begin
      model_window[i] = '0;
      model_staged[i] = '0;
      model_live[i]   = '0;
    end

    cycles = 0;
    while (rst !== 1'b0)
    begin
      cycles++;
      if (cycles > WAIT_LIMIT)
        abort_run("Reset was never released");
      @(posedge tb_clk);
    end

    // Everything reads zero out of reset
    expect_reg("reset status", ADDR_STATUS, 16'h0000);
    expect_reg("reset result", ADDR_RESULT, 16'h0000);
    expect_reg("reset sample", ADDR_SAMPLE, 16'h0000);
    for (i = 0; i < NUM_TAPS; i++)
      expect_reg($sformatf("reset coef %0d", i), coef_addr(i), 16'h0000);
    expect_reg("reset coef_set", ADDR_COEF_SET, 16'h0000);

    // Staged coefficient readback
    for (i = 0; i < NUM_TAPS; i++)
      set_coef(i, 16'h1234 + 16'h1111 * i);
    for (i = 0; i < NUM_TAPS; i++)
      expect_reg($sformatf("coef %0d readback", i), coef_addr(i), model_staged[i]);

    // Illegal accesses, 4 bit address space has nothing at 16 or above
    expect_rejected("write to status", 1'b1, ADDR_STATUS, 16'h0003);
    expect_rejected("write to result", 1'b1, ADDR_RESULT, 16'hbeef);
    expect_rejected("odd address write", 1'b1, ADDR_COEF_BASE + 4'd1, 16'hdead);
    expect_rejected("odd address read", 1'b0, 4'd3, 16'h0000);
    expect_rejected("coef_set write of 2", 1'b1, ADDR_COEF_SET, 16'h0002);
    // Read while a wrongly started copy would still be running
    expect_reg("coef_set after bad value", ADDR_COEF_SET, 16'h0000);
    expect_reg("status after rejects", ADDR_STATUS, 16'h0000);
    expect_reg("result after rejects", ADDR_RESULT, 16'h0000);
    expect_reg("coef 0 after odd write", coef_addr(0), model_staged[0]);

    // New weights must reach the live taps
    commit_coefs();
    send_sample(16'h3000);
    check_output("commit");

    // Unity, unity, half, half
    set_coef(0, 16'h8000);
    set_coef(1, 16'h8000);
    set_coef(2, 16'h4000);
    set_coef(3, 16'h4000);
    commit_coefs();
    send_sample(16'd2);
    send_sample(16'd2);
    send_sample(16'd5);
    send_sample(16'd1);
    check_output("filter");
    expect_reg("filter known result", ADDR_RESULT, 16'd4);
    expect_reg("filter known status", ADDR_STATUS, 16'h0000);
    for (i = 0; i < 20; i++)
    begin
      send_sample(random_sample());
      check_output($sformatf("random %0d", i));
    end

    // Negative sum sets err
    for (i = 0; i < NUM_TAPS; i++)
      set_coef(i, 16'h8000);
    commit_coefs();
    send_sample(16'h0000);
    send_sample(16'hffff);
    send_sample(16'hffff);
    send_sample(16'h00ff);
    check_output("overflow");
    read_reg(ADDR_STATUS, status);
    check_value("overflow err set", 1, status[STATUS_ERR_BIT]);
    // Sum back to 239
    send_sample(16'h0010);
    check_output("recover");
    read_reg(ADDR_STATUS, status);
    check_value("recover err clear", 0, status[STATUS_ERR_BIT]);

    // No polling, later writes must stall on pready
    for (i = 0; i < 6; i++)
    begin
      send_sample(random_sample());
      if (i > 0)
      begin
        assert (last_stalls > 0)
        else
          abort_run("Sample write completed while the engine was still busy");
      end
    end
    check_output("back-pressure");

    $display("=== PASS ===");
    $finish;
  end

endmodule

/* tb/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic tb_clk,
  output logic rst
);

  localparam int RESET_CYCLES = 10;

  // 10 ns period
  initial
  begin
    tb_clk = 1'b0;
    forever
      #5 tb_clk = ~tb_clk;
  end

  // Released just after an edge, like every other input
  initial
  begin
    rst = 1'b1;
    repeat (RESET_CYCLES)
      @(posedge tb_clk);
    #1 rst = 1'b0;
  end

endmodule
